// ==== Bender.yml ====
package:
  name: mem_fabric

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/mem_access_pkg.sv
      - hw/bus_pkg.sv
      - hw/wb_if.sv
      - hw/lsu_lane_align.sv
      - hw/region_router.sv
      - hw/mem_arbiter.sv
      - hw/sram_wb.sv
      - hw/mem_fabric_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - verification/tb_mem_fabric.sv

// ==== all.f ====
+incdir+hw
hw/mem_access_pkg.sv
hw/bus_pkg.sv
hw/wb_if.sv
hw/lsu_lane_align.sv
hw/region_router.sv
hw/mem_arbiter.sv
hw/sram_wb.sv
hw/mem_fabric_top.sv
verification/tb_mem_fabric.sv

// ==== hw/bus_pkg.sv ====
`default_nettype none

`include "mem_defines.svh"

package bus_pkg;

    // ********************
    // bus side types
    // ********************

    typedef logic [`MEM_ADDR_W-1:0] bus_addr_t;
    typedef logic [`MEM_DATA_W-1:0] bus_data_t;
    typedef logic [`MEM_SEL_W-1:0]  bus_sel_t;

    // where a data access ends up
    typedef enum logic {
        REGION_RAM = 1'b0,
        REGION_DEV = 1'b1
    } region_e;

endpackage

`default_nettype wire

// ==== hw/lsu_lane_align.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "mem_defines.svh"

module lsu_lane_align (
    input  wire                           clk,
    input  wire                           rst_n_i,
    input  wire                           lsu_cyc_i,
    input  wire                           lsu_stb_i,
    input  wire                           lsu_we_i,
    input  wire bus_pkg::bus_addr_t       lsu_adr_i,
    input  wire mem_access_pkg::access_size_e lsu_size_i,
    input  wire                           lsu_unsigned_i,
    input  wire bus_pkg::bus_data_t       lsu_dat_i,
    output bus_pkg::bus_data_t            lsu_dat_o,
    output logic                          lsu_ack_o,
    wb_if.master                          bus_o
);

    localparam int OFF_W = $clog2(`MEM_SEL_W);

    logic [OFF_W-1:0]   off_live;
    bus_pkg::bus_sel_t  sel_base;
    bus_pkg::bus_data_t wdata;
    bus_pkg::bus_data_t shifted;

    // ********************
    // request side
    // ********************

    // lane pattern and replicated store data per size
    always_comb begin
        off_live = lsu_adr_i[OFF_W-1:0];
        sel_base = 8'hff;
        wdata    = lsu_dat_i;
        case (lsu_size_i)
            mem_access_pkg::SIZE_BYTE: begin
                sel_base = 8'h01;
                wdata    = {8{lsu_dat_i[7:0]}};
            end
            mem_access_pkg::SIZE_HALF: begin
                off_live[0] = 1'b0;
                sel_base    = 8'h03;
                wdata       = {4{lsu_dat_i[15:0]}};
            end
            mem_access_pkg::SIZE_WORD: begin
                off_live[1:0] = 2'b00;
                sel_base      = 8'h0f;
                wdata         = {2{lsu_dat_i[31:0]}};
            end
            default: begin
                off_live = '0;
            end
        endcase
    end

    assign bus_o.cyc   = lsu_cyc_i;
    assign bus_o.stb   = lsu_stb_i;
    assign bus_o.we    = lsu_we_i;
    assign bus_o.adr   = lsu_adr_i & ~bus_pkg::bus_addr_t'(`MEM_SEL_W - 1);
    assign bus_o.sel   = sel_base << off_live;
    assign bus_o.dat_w = wdata;

    // ********************
    // load return
    // ********************

    assign shifted = bus_o.dat_r >> {off_live, 3'b000};

    always_comb begin
        case (lsu_size_i)
            mem_access_pkg::SIZE_BYTE:
                lsu_dat_o = {{(`MEM_DATA_W-8){!lsu_unsigned_i && shifted[7]}}, shifted[7:0]};
            mem_access_pkg::SIZE_HALF:
                lsu_dat_o = {{(`MEM_DATA_W-16){!lsu_unsigned_i && shifted[15]}},
                             shifted[15:0]};
            mem_access_pkg::SIZE_WORD:
                lsu_dat_o = {{(`MEM_DATA_W-32){!lsu_unsigned_i && shifted[31]}},
                             shifted[31:0]};
            default:
                lsu_dat_o = shifted;
        endcase
    end

    assign lsu_ack_o = bus_o.ack;

endmodule

`default_nettype wire

// ==== hw/mem_access_pkg.sv ====
`default_nettype none

package mem_access_pkg;

    // ********************
    // core side of a load/store
    // ********************

    // width of one access, lanes covered are 1, 2, 4 or 8 bytes
    typedef enum logic [1:0] {
        SIZE_BYTE   = 2'd0,
        SIZE_HALF   = 2'd1,
        SIZE_WORD   = 2'd2,
        SIZE_DOUBLE = 2'd3
    } access_size_e;

endpackage

`default_nettype wire

// ==== hw/mem_arbiter.sv ====
`timescale 1ns/100ps
`default_nettype none

module mem_arbiter (
    input  wire  clk,
    input  wire  rst_n_i,
    wb_if.slave  data_bus_i,
    wb_if.slave  fetch_bus_i,
    wb_if.master sram_bus_o
);

    typedef enum logic [1:0] {
        GNT_IDLE  = 2'd0,
        GNT_DATA  = 2'd1,
        GNT_FETCH = 2'd2
    } grant_e;

    grant_e grant_q;
    grant_e grant_d;
    logic   data_req;
    logic   fetch_req;

    assign data_req  = data_bus_i.cyc && data_bus_i.stb;
    assign fetch_req = fetch_bus_i.cyc && fetch_bus_i.stb;

    // ********************
    // grant FSM
    // ********************

    // data first, grant held for the whole beat of the owner
    always_comb begin
        grant_d = grant_q;
        case (grant_q)
            GNT_IDLE: begin
                if (data_req) begin
                    grant_d = GNT_DATA;
                end else if (fetch_req) begin
                    grant_d = GNT_FETCH;
                end
            end
            GNT_DATA: begin
                if ((sram_bus_o.ack && data_bus_i.stb) || !data_bus_i.cyc) begin
                    grant_d = GNT_IDLE;
                end
            end
            GNT_FETCH: begin
                if ((sram_bus_o.ack && fetch_bus_i.stb) || !fetch_bus_i.cyc) begin
                    grant_d = GNT_IDLE;
                end
            end
            default: grant_d = GNT_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            grant_q <= GNT_IDLE;
        end else begin
            grant_q <= grant_d;
        end
    end

    // ********************
    // owner to sram
    // ********************

    always_comb begin
        sram_bus_o.cyc   = 1'b0;
        sram_bus_o.stb   = 1'b0;
        sram_bus_o.we    = 1'b0;
        sram_bus_o.adr   = data_bus_i.adr;
        sram_bus_o.sel   = data_bus_i.sel;
        sram_bus_o.dat_w = data_bus_i.dat_w;
        case (grant_q)
            GNT_DATA: begin
                sram_bus_o.cyc = data_bus_i.cyc;
                sram_bus_o.stb = data_bus_i.stb;
                sram_bus_o.we  = data_bus_i.we;
            end
            GNT_FETCH: begin
                // fetch is read only
                sram_bus_o.cyc = fetch_bus_i.cyc;
                sram_bus_o.stb = fetch_bus_i.stb;
                sram_bus_o.adr = fetch_bus_i.adr;
                sram_bus_o.sel = fetch_bus_i.sel;
            end
            default: begin
                sram_bus_o.cyc = 1'b0;
            end
        endcase
    end

    assign data_bus_i.dat_r  = sram_bus_o.dat_r;
    assign fetch_bus_i.dat_r = sram_bus_o.dat_r;
    assign data_bus_i.ack    = (grant_q == GNT_DATA) && sram_bus_o.ack;
    assign fetch_bus_i.ack   = (grant_q == GNT_FETCH) && sram_bus_o.ack;

endmodule

`default_nettype wire

// ==== hw/mem_defines.svh ====
`ifndef MEM_DEFINES_SVH
`define MEM_DEFINES_SVH

// ********************
// bus widths
// ********************

`define MEM_ADDR_W 32
`define MEM_DATA_W 64
`define MEM_SEL_W 8

// ********************
// memory map
// ********************

// RAM window, limit is the first address past it
`define RAM_BASE 32'h8000_0000
`define RAM_LIMIT 32'h8800_0000

// sram depth in doublewords, log2
`define SRAM_DEPTH_LOG2 10

`endif

// ==== hw/mem_fabric_top.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "mem_defines.svh"

module mem_fabric_top (
    input  wire                               clk,
    input  wire                               rst_n_i,
    // instruction fetch
    input  wire                               fetch_cyc_i,
    input  wire                               fetch_stb_i,
    input  wire bus_pkg::bus_addr_t           fetch_adr_i,
    output bus_pkg::bus_data_t                fetch_dat_o,
    output logic                              fetch_ack_o,
    // load/store
    input  wire                               lsu_cyc_i,
    input  wire                               lsu_stb_i,
    input  wire                               lsu_we_i,
    input  wire bus_pkg::bus_addr_t           lsu_adr_i,
    input  wire mem_access_pkg::access_size_e lsu_size_i,
    input  wire                               lsu_unsigned_i,
    input  wire bus_pkg::bus_data_t           lsu_dat_i,
    output bus_pkg::bus_data_t                lsu_dat_o,
    output logic                              lsu_ack_o,
    // uncached device port
    output logic                              dev_cyc_o,
    output logic                              dev_stb_o,
    output logic                              dev_we_o,
    output bus_pkg::bus_addr_t                dev_adr_o,
    output bus_pkg::bus_sel_t                 dev_sel_o,
    output bus_pkg::bus_data_t                dev_dat_o,
    input  wire bus_pkg::bus_data_t           dev_dat_i,
    input  wire                               dev_ack_i
);

    wb_if lsu_bus ();
    wb_if ram_data_bus ();
    wb_if fetch_bus ();
    wb_if sram_bus ();
    wb_if dev_bus ();

    // ********************
    // fetch side
    // ********************

    // whole aligned doubleword, all lanes
    assign fetch_bus.cyc   = fetch_cyc_i;
    assign fetch_bus.stb   = fetch_stb_i;
    assign fetch_bus.we    = 1'b0;
    assign fetch_bus.adr   = fetch_adr_i & ~bus_pkg::bus_addr_t'(`MEM_SEL_W - 1);
    assign fetch_bus.sel   = '1;
    assign fetch_bus.dat_w = '0;
    assign fetch_dat_o     = fetch_bus.dat_r;
    assign fetch_ack_o     = fetch_bus.ack;

    // ********************
    // data side
    // ********************

    lsu_lane_align i_lsu_lane_align (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .lsu_cyc_i      (lsu_cyc_i),
        .lsu_stb_i      (lsu_stb_i),
        .lsu_we_i       (lsu_we_i),
        .lsu_adr_i      (lsu_adr_i),
        .lsu_size_i     (lsu_size_i),
        .lsu_unsigned_i (lsu_unsigned_i),
        .lsu_dat_i      (lsu_dat_i),
        .lsu_dat_o      (lsu_dat_o),
        .lsu_ack_o      (lsu_ack_o),
        .bus_o          (lsu_bus.master)
    );

    region_router i_region_router (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .lsu_bus_i (lsu_bus.slave),
        .ram_bus_o (ram_data_bus.master),
        .dev_bus_o (dev_bus.master)
    );

    mem_arbiter i_mem_arbiter (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .data_bus_i  (ram_data_bus.slave),
        .fetch_bus_i (fetch_bus.slave),
        .sram_bus_o  (sram_bus.master)
    );

    sram_wb i_sram_wb (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .bus_i   (sram_bus.slave)
    );

    // uncached beats leave the fabric here
    assign dev_cyc_o     = dev_bus.cyc;
    assign dev_stb_o     = dev_bus.stb;
    assign dev_we_o      = dev_bus.we;
    assign dev_adr_o     = dev_bus.adr;
    assign dev_sel_o     = dev_bus.sel;
    assign dev_dat_o     = dev_bus.dat_w;
    assign dev_bus.dat_r = dev_dat_i;
    assign dev_bus.ack   = dev_ack_i;

endmodule

`default_nettype wire

// ==== hw/region_router.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "mem_defines.svh"

module region_router (
    input  wire  clk,
    input  wire  rst_n_i,
    wb_if.slave  lsu_bus_i,
    wb_if.master ram_bus_o,
    wb_if.master dev_bus_o
);

    bus_pkg::region_e region;

    // inside the RAM window goes to sram, the rest stays uncached
    assign region = (lsu_bus_i.adr >= bus_pkg::bus_addr_t'(`RAM_BASE) &&
                     lsu_bus_i.adr <  bus_pkg::bus_addr_t'(`RAM_LIMIT)) ?
                    bus_pkg::REGION_RAM : bus_pkg::REGION_DEV;

    // ********************
    // steering
    // ********************

    assign ram_bus_o.cyc   = lsu_bus_i.cyc && (region == bus_pkg::REGION_RAM);
    assign ram_bus_o.stb   = lsu_bus_i.stb && (region == bus_pkg::REGION_RAM);
    assign ram_bus_o.we    = lsu_bus_i.we;
    assign ram_bus_o.adr   = lsu_bus_i.adr;
    assign ram_bus_o.sel   = lsu_bus_i.sel;
    assign ram_bus_o.dat_w = lsu_bus_i.dat_w;

    assign dev_bus_o.cyc   = lsu_bus_i.cyc && (region == bus_pkg::REGION_DEV);
    assign dev_bus_o.stb   = lsu_bus_i.stb && (region == bus_pkg::REGION_DEV);
    assign dev_bus_o.we    = lsu_bus_i.we;
    assign dev_bus_o.adr   = lsu_bus_i.adr;
    assign dev_bus_o.sel   = lsu_bus_i.sel;
    assign dev_bus_o.dat_w = lsu_bus_i.dat_w;

    // response of the selected side only
    assign lsu_bus_i.dat_r = (region == bus_pkg::REGION_RAM) ? ram_bus_o.dat_r
                                                             : dev_bus_o.dat_r;
    assign lsu_bus_i.ack   = (region == bus_pkg::REGION_RAM) ? ram_bus_o.ack
                                                             : dev_bus_o.ack;

endmodule

`default_nettype wire

// ==== hw/sram_wb.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "mem_defines.svh"

module sram_wb #(
    parameter int DEPTH_LOG2 = `SRAM_DEPTH_LOG2
) (
    input wire  clk,
    input wire  rst_n_i,
    wb_if.slave bus_i
);

    localparam int OFF_W = $clog2(`MEM_SEL_W);

    bus_pkg::bus_data_t    mem [2**DEPTH_LOG2];
    bus_pkg::bus_data_t    rdata_q;
    logic [DEPTH_LOG2-1:0] idx;
    logic                  ack_q;
    logic                  beat;

    // doubleword index, wraps modulo the array size
    assign idx  = bus_i.adr[OFF_W +: DEPTH_LOG2];
    assign beat = bus_i.cyc && bus_i.stb && !ack_q;

    // ********************
    // ack
    // ********************

    // one cycle after the request, never back to back
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= beat;
        end
    end

    // ********************
    // array
    // ********************

    always_ff @(posedge clk) begin
        if (beat) begin
            rdata_q <= mem[idx];
            if (bus_i.we) begin
                for (int i = 0; i < `MEM_SEL_W; i++) begin
                    if (bus_i.sel[i]) begin
                        mem[idx][8*i +: 8] <= bus_i.dat_w[8*i +: 8];
                    end
                end
            end
        end
    end

    assign bus_i.ack   = ack_q;
    assign bus_i.dat_r = rdata_q;

endmodule

`default_nettype wire

// ==== hw/wb_if.sv ====
`timescale 1ns/100ps
`default_nettype none

// wishbone classic, one beat per handshake
interface wb_if;

    logic               cyc;
    logic               stb;
    logic               we;
    bus_pkg::bus_addr_t adr;
    bus_pkg::bus_sel_t  sel;
    bus_pkg::bus_data_t dat_w;
    bus_pkg::bus_data_t dat_r;
    logic               ack;

    // request side, held steady until ack
    modport master (
        output cyc, stb, we, adr, sel, dat_w,
        input  dat_r, ack
    );

    // response side, one ack per beat
    modport slave (
        input  cyc, stb, we, adr, sel, dat_w,
        output dat_r, ack
    );

endinterface

`default_nettype wire

// ==== verification/tb_mem_fabric.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "mem_defines.svh"

module tb_mem_fabric;

    localparam int ACK_TIMEOUT = 20;

    logic                         clk;
    logic                         rst_n_i;
    logic                         fetch_cyc_i;
    logic                         fetch_stb_i;
    bus_pkg::bus_addr_t           fetch_adr_i;
    bus_pkg::bus_data_t           fetch_dat_o;
    logic                         fetch_ack_o;
    logic                         lsu_cyc_i;
    logic                         lsu_stb_i;
    logic                         lsu_we_i;
    bus_pkg::bus_addr_t           lsu_adr_i;
    mem_access_pkg::access_size_e lsu_size_i;
    logic                         lsu_unsigned_i;
    bus_pkg::bus_data_t           lsu_dat_i;
    bus_pkg::bus_data_t           lsu_dat_o;
    logic                         lsu_ack_o;
    logic                         dev_cyc_o;
    logic                         dev_stb_o;
    logic                         dev_we_o;
    bus_pkg::bus_addr_t           dev_adr_o;
    bus_pkg::bus_sel_t            dev_sel_o;
    bus_pkg::bus_data_t           dev_dat_o;
    bus_pkg::bus_data_t           dev_dat_i;
    logic                         dev_ack_i;

    logic [15:0]        lfsr_q;
    int                 err_cnt;
    int                 test_cnt;
    int                 failed_tests;
    bus_pkg::bus_data_t dev_mem [8];
    int                 dev_delay;
    int                 dev_idx;
    // dev port as seen on the last lsu ack
    bus_pkg::bus_addr_t seen_dev_adr;
    bus_pkg::bus_sel_t  seen_dev_sel;
    bus_pkg::bus_data_t seen_dev_dat;
    logic               seen_dev_we;
    logic               seen_dev_cyc;
    logic               seen_dev_stb;

    mem_fabric_top i_mem_fabric_top (.*);

    always #5 clk = ~clk;

    // ********************
    // stimulus helpers
    // ********************

    // x^16 + x^14 + x^13 + x^11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];
        return {s[14:0], fb};
    endfunction

    // one lfsr step per bit taken
    function automatic bus_pkg::bus_data_t take_bits(input int n);
        bus_pkg::bus_data_t r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            r      = {r[62:0], lfsr_q[0]};
        end
        return r;
    endfunction

    function automatic bus_pkg::bus_data_t dev_fill(input int idx);
        return {8{8'(idx * 37 + 5)}};
    endfunction

    // ********************
    // expected values
    // ********************

    function automatic bus_pkg::bus_sel_t lane_sel(input int size, input int off);
        bus_pkg::bus_sel_t s;
        s = '0;
        for (int i = 0; i < (1 << size); i++) begin
            s[off + i] = 1'b1;
        end
        return s;
    endfunction

    function automatic bus_pkg::bus_data_t replicate(input bus_pkg::bus_data_t val,
                                                     input int size);
        bus_pkg::bus_data_t r;
        for (int i = 0; i < 8; i++) begin
            r[8*i +: 8] = val[8*(i % (1 << size)) +: 8];
        end
        return r;
    endfunction

    function automatic bus_pkg::bus_data_t merge_store(input bus_pkg::bus_data_t old,
                                                       input bus_pkg::bus_data_t val,
                                                       input int size, input int off);
        bus_pkg::bus_data_t r;
        r = old;
        for (int i = 0; i < (1 << size); i++) begin
            r[8*(off + i) +: 8] = val[8*i +: 8];
        end
        return r;
    endfunction

    // addressed lanes moved down, upper bits by sign or zero
    function automatic bus_pkg::bus_data_t extend_load(input bus_pkg::bus_data_t dword,
                                                       input int size, input int off,
                                                       input logic uns);
        bus_pkg::bus_data_t v;
        int                 nbits;
        v     = dword >> (8 * off);
        nbits = 8 << size;
        for (int i = nbits; i < 64; i++) begin
            v[i] = uns ? 1'b0 : v[nbits - 1];
        end
        return v;
    endfunction

    // ********************
    // compare tasks
    // ********************

    task automatic check_data(input bus_pkg::bus_data_t got, input bus_pkg::bus_data_t exp,
                              input string what);
        if (got !== exp) begin
            $display("** Error at %0d ns: %s is %h, expected %h", $time, what, got, exp);
            err_cnt++;
        end
    endtask

    task automatic check_sel(input bus_pkg::bus_sel_t got, input bus_pkg::bus_sel_t exp,
                             input string what);
        if (got !== exp) begin
            $display("** Error at %0d ns: %s is %h, expected %h", $time, what, got, exp);
            err_cnt++;
        end
    endtask

    task automatic check_addr(input bus_pkg::bus_addr_t got, input bus_pkg::bus_addr_t exp,
                              input string what);
        if (got !== exp) begin
            $display("** Error at %0d ns: %s is %h, expected %h", $time, what, got, exp);
            err_cnt++;
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("** Error at %0d ns: %s is %b, expected %b", $time, what, got, exp);
            err_cnt++;
        end
    endtask

    task automatic finish_test(input string name, input int errs_before);
        test_cnt++;
        if (err_cnt == errs_before) begin
            $display("test %s: passed", name);
        end else begin
            failed_tests++;
            $display("test %s: %0d errors", name, err_cnt - errs_before);
        end
    endtask

    // ********************
    // bus drivers
    // ********************

    // called 1 ns after a rising edge, returns 1 ns after the ack edge
    task automatic lsu_access(input logic we, input bus_pkg::bus_addr_t adr, input int size,
                              input logic uns, input bus_pkg::bus_data_t wdat,
                              output bus_pkg::bus_data_t rdat, output int cycles);
        logic seen;
        seen           = 1'b0;
        cycles         = 0;
        rdat           = '0;
        lsu_cyc_i      = 1'b1;
        lsu_stb_i      = 1'b1;
        lsu_we_i       = we;
        lsu_adr_i      = adr;
        lsu_size_i     = mem_access_pkg::access_size_e'(size);
        lsu_unsigned_i = uns;
        lsu_dat_i      = wdat;
        while (!seen && cycles < ACK_TIMEOUT) begin
            @(negedge clk);
            if (lsu_ack_o) begin
                seen         = 1'b1;
                rdat         = lsu_dat_o;
                seen_dev_adr = dev_adr_o;
                seen_dev_sel = dev_sel_o;
                seen_dev_dat = dev_dat_o;
                seen_dev_we  = dev_we_o;
                seen_dev_cyc = dev_cyc_o;
                seen_dev_stb = dev_stb_o;
            end else begin
                cycles++;
            end
        end
        if (!seen) begin
            $display("lsu access to %h timed out with no ack after %0d cycles", adr, cycles);
            err_cnt++;
        end
        @(posedge clk);
        #1;
        lsu_cyc_i = 1'b0;
        lsu_stb_i = 1'b0;
        lsu_we_i  = 1'b0;
    endtask

    task automatic fetch(input bus_pkg::bus_addr_t adr, output bus_pkg::bus_data_t got,
                         output int cycles);
        logic seen;
        seen        = 1'b0;
        cycles      = 0;
        got         = '0;
        fetch_cyc_i = 1'b1;
        fetch_stb_i = 1'b1;
        fetch_adr_i = adr;
        while (!seen && cycles < ACK_TIMEOUT) begin
            @(negedge clk);
            if (fetch_ack_o) begin
                seen = 1'b1;
                got  = fetch_dat_o;
            end else begin
                cycles++;
            end
        end
        if (!seen) begin
            $display("fetch from %h timed out with no ack after %0d cycles", adr, cycles);
            err_cnt++;
        end
        @(posedge clk);
        #1;
        fetch_cyc_i = 1'b0;
        fetch_stb_i = 1'b0;
    endtask

    task automatic store(input bus_pkg::bus_addr_t adr, input int size,
                         input bus_pkg::bus_data_t val);
        bus_pkg::bus_data_t unused;
        int                 cyc;
        lsu_access(1'b1, adr, size, 1'b0, val, unused, cyc);
    endtask

    task automatic load(input bus_pkg::bus_addr_t adr, input int size, input logic uns,
                        output bus_pkg::bus_data_t got);
        int cyc;
        lsu_access(1'b0, adr, size, uns, '0, got, cyc);
    endtask

    // ********************
    // device responder
    // ********************

    always begin
        @(negedge clk);
        if (dev_cyc_o && dev_stb_o) begin
            dev_delay = int'(take_bits(2));
            repeat (dev_delay) @(posedge clk);
            @(posedge clk);
            #1;
            dev_idx   = int'(dev_adr_o[5:3]);
            dev_dat_i = dev_mem[dev_idx];
            if (dev_we_o) begin
                for (int i = 0; i < 8; i++) begin
                    if (dev_sel_o[i]) begin
                        dev_mem[dev_idx][8*i +: 8] = dev_dat_o[8*i +: 8];
                    end
                end
            end
            dev_ack_i = 1'b1;
            @(posedge clk);
            #1;
            dev_ack_i = 1'b0;
        end
    end

    // ********************
    // tests
    // ********************

    task automatic test_fetch_after_store();
        int                 e0;
        int                 cyc;
        bus_pkg::bus_data_t val;
        bus_pkg::bus_data_t got;
        e0  = err_cnt;
        val = take_bits(64);
        store(`RAM_BASE + 32'h100, 3, val);
        fetch(`RAM_BASE + 32'h100, got, cyc);
        check_data(got, val, "fetch data");
        if (cyc != 2) begin
            $display("** Error at %0d ns: fetch ack after %0d cycles, expected 2", $time, cyc);
            err_cnt++;
        end
        finish_test("fetch after store", e0);
    endtask

    task automatic test_partial_merge();
        int                 e0;
        bus_pkg::bus_addr_t base;
        bus_pkg::bus_data_t exp;
        bus_pkg::bus_data_t val;
        bus_pkg::bus_data_t got;
        int                 sizes [5] = '{0, 1, 2, 0, 1};
        int                 offs  [5] = '{3, 6, 0, 5, 2};
        e0   = err_cnt;
        base = `RAM_BASE + 32'h200;
        exp  = take_bits(64);
        store(base, 3, exp);
        for (int k = 0; k < 5; k++) begin
            val = take_bits(64);
            store(base + offs[k], sizes[k], val);
            exp = merge_store(exp, val, sizes[k], offs[k]);
        end
        load(base, 3, 1'b0, got);
        check_data(got, exp, "merged doubleword");
        finish_test("partial stores merge", e0);
    endtask

    task automatic test_load_extension();
        int                 e0;
        bus_pkg::bus_addr_t base;
        bus_pkg::bus_data_t pattern;
        bus_pkg::bus_data_t got;
        e0   = err_cnt;
        base = `RAM_BASE + 32'h300;
        pattern = take_bits(64);
        // second pass flips every lane sign bit
        for (int p = 0; p < 2; p++) begin
            if (p == 1) begin
                pattern = pattern ^ 64'h8080_8080_8080_8080;
            end
            store(base, 3, pattern);
            for (int size = 0; size < 4; size++) begin
                for (int off = 0; off < 8; off += (1 << size)) begin
                    for (int uns = 0; uns < 2; uns++) begin
                        load(base + off, size, uns[0], got);
                        check_data(got, extend_load(pattern, size, off, uns[0]),
                                   $sformatf("load size %0d off %0d uns %0d", size, off, uns));
                    end
                end
            end
        end
        finish_test("load extension", e0);
    endtask

    task automatic test_device_region();
        int                 e0;
        bus_pkg::bus_addr_t low_adr;
        bus_pkg::bus_addr_t high_adr;
        bus_pkg::bus_data_t guard_lo;
        bus_pkg::bus_data_t guard_hi;
        bus_pkg::bus_data_t v1;
        bus_pkg::bus_data_t v2;
        bus_pkg::bus_data_t got;
        e0       = err_cnt;
        low_adr  = 32'h1000_0014;
        high_adr = `RAM_LIMIT + 32'h1a;
        // same sram index as the two device addresses
        guard_lo = take_bits(64);
        guard_hi = take_bits(64);
        store(`RAM_BASE + 32'h10, 3, guard_lo);
        store(`RAM_BASE + 32'h18, 3, guard_hi);
        v1 = take_bits(32);
        store(low_adr, 2, v1);
        check_flag(seen_dev_cyc, 1'b1, "dev cyc, low store");
        check_flag(seen_dev_stb, 1'b1, "dev stb, low store");
        check_addr(seen_dev_adr, 32'h1000_0010, "dev address, low store");
        check_sel(seen_dev_sel, lane_sel(2, 4), "dev sel, low store");
        check_data(seen_dev_dat, replicate(v1, 2), "dev data, low store");
        check_flag(seen_dev_we, 1'b1, "dev we, low store");
        v2 = take_bits(16);
        store(high_adr, 1, v2);
        check_flag(seen_dev_cyc, 1'b1, "dev cyc, high store");
        check_flag(seen_dev_stb, 1'b1, "dev stb, high store");
        check_addr(seen_dev_adr, `RAM_LIMIT + 32'h18, "dev address, high store");
        check_sel(seen_dev_sel, lane_sel(1, 2), "dev sel, high store");
        check_data(seen_dev_dat, replicate(v2, 1), "dev data, high store");
        check_flag(seen_dev_we, 1'b1, "dev we, high store");
        load(low_adr, 2, 1'b0, got);
        check_data(got, extend_load(merge_store(dev_fill(2), v1, 2, 4), 2, 4, 1'b0),
                   "dev load, signed word");
        check_flag(seen_dev_we, 1'b0, "dev we, low load");
        load(high_adr, 1, 1'b1, got);
        check_data(got, extend_load(merge_store(dev_fill(3), v2, 1, 2), 1, 2, 1'b1),
                   "dev load, unsigned half");
        load(`RAM_BASE + 32'h10, 3, 1'b0, got);
        check_data(got, guard_lo, "ram guard below device store");
        check_flag(seen_dev_cyc, 1'b0, "dev cyc, ram load");
        check_flag(seen_dev_stb, 1'b0, "dev stb, ram load");
        load(`RAM_BASE + 32'h18, 3, 1'b0, got);
        check_data(got, guard_hi, "ram guard above device store");
        finish_test("device region", e0);
    endtask

    task automatic test_contention();
        int                 e0;
        int                 f_cyc;
        int                 l_cyc;
        bus_pkg::bus_data_t a;
        bus_pkg::bus_data_t b;
        bus_pkg::bus_data_t f_got;
        bus_pkg::bus_data_t l_got;
        e0 = err_cnt;
        a  = take_bits(64);
        b  = take_bits(64);
        store(`RAM_BASE + 32'h400, 3, a);
        store(`RAM_BASE + 32'h408, 3, b);
        fork
            fetch(`RAM_BASE + 32'h400, f_got, f_cyc);
            lsu_access(1'b0, `RAM_BASE + 32'h408, 3, 1'b0, '0, l_got, l_cyc);
        join
        check_data(f_got, a, "fetch data under contention");
        check_data(l_got, b, "lsu data under contention");
        if (l_cyc >= f_cyc) begin
            $display("** Error at %0d ns: lsu ack at cycle %0d not before fetch ack at %0d",
                     $time, l_cyc, f_cyc);
            err_cnt++;
        end
        finish_test("contention", e0);
    endtask

    initial begin
        clk            = 1'b0;
        rst_n_i        = 1'b0;
        fetch_cyc_i    = 1'b0;
        fetch_stb_i    = 1'b0;
        fetch_adr_i    = '0;
        lsu_cyc_i      = 1'b0;
        lsu_stb_i      = 1'b0;
        lsu_we_i       = 1'b0;
        lsu_adr_i      = '0;
        lsu_size_i     = mem_access_pkg::SIZE_BYTE;
        lsu_unsigned_i = 1'b0;
        lsu_dat_i      = '0;
        dev_dat_i      = '0;
        dev_ack_i      = 1'b0;
        lfsr_q         = 16'd62138;
        err_cnt        = 0;
        test_cnt       = 0;
        failed_tests   = 0;
        for (int i = 0; i < 8; i++) begin
            dev_mem[i] = dev_fill(i);
        end
        repeat (8) @(posedge clk);
        #1;
        rst_n_i = 1'b1;
        test_fetch_after_store();
        test_partial_merge();
        test_load_extension();
        test_device_region();
        test_contention();
        $display("tests run %0d, tests failed %0d, errors %0d", test_cnt, failed_tests,
                 err_cnt);
        if (err_cnt == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
